/* compile.f */
+incdir+tests
source/controlPkg.sv
source/instrDecoder.sv
source/controlSequencer.sv
source/controlWordGen.sv
source/controlUnit.sv
tests/controlUnitTb.sv

/* Bender.yml */
package:
  name: control_unit

sources:
  - files:
      - source/controlPkg.sv
      - source/instrDecoder.sv
      - source/controlSequencer.sv
      - source/controlWordGen.sv
      - source/controlUnit.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/controlUnitTb.sv

/* tests/controlModel.svh */
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// Reference phase and step, advanced once per rising edge
phase_t      modelPhase     = phaseBoot;
step_t       modelStep      = '0;
int          completedCount = 0;
// One bit per phase entered from decode, bit 1 marks an unsupported encoding
logic [11:0] seenMask       = '0;

// Execute phase for an encoding, Fetch1 when it is not supported
function automatic phase_t decodeExpected(input opcode_t op, input funct_t fn);
    if (op == OPCODE_ADDM) begin
        return phaseAddm;
    end
    if (op != OPCODE_RTYPE) begin
        return phaseFetch1;
    end
    case (fn)
        FUNCT_ADD:   return phaseAdd;
        FUNCT_SUB:   return phaseSub;
        FUNCT_BREAK: return phaseBreak;
        FUNCT_RTE:   return phaseRte;
        FUNCT_DIVM:  return phaseDivm;
        default:     return phaseFetch1;
    endcase
endfunction

// Number of execute cycles of each instruction
function automatic int execLength(input phase_t p);
    case (p)
        phaseAdd, phaseSub:   return 2;
        phaseBreak, phaseRte: return 1;
        phaseAddm:            return 6;
        // Two operand reads, the divide itself, then HI/LO
        phaseDivm:            return 5 + DIV_CYCLES + 1;
        default:              return 0;
    endcase
endfunction

task automatic advanceModel(input logic rst, input opcode_t op, input funct_t fn);
    phase_t nextPhase;
    if (rst) begin
        modelPhase = phaseBoot;
        modelStep  = '0;
    end else if (modelPhase == phaseDecode) begin
        nextPhase = decodeExpected(op, fn);
        seenMask[int'(nextPhase)] = 1'b1;
        if (nextPhase == phaseFetch1) begin
            completedCount++;
        end
        modelPhase = nextPhase;
        modelStep  = '0;
    end else if (modelPhase < phaseDecode) begin
        // Boot and fetch phases follow enum order
        modelPhase = phase_t'(modelPhase + 1);
    end else if (int'(modelStep) + 1 == execLength(modelPhase)) begin
        modelPhase = phaseFetch1;
        modelStep  = '0;
        completedCount++;
    end else begin
        modelStep = modelStep + 6'd1;
    end
endtask

function automatic controlWord_t expectedControl(input phase_t p, input step_t s);
    controlWord_t w;
    w = '0;
    case (p)
        phaseFetch1, phaseFetch2, phaseIrWrite: begin
            w.iorD     = IORD_PC;
            w.aluOp    = ALU_ADD;
            w.aluSrcA  = SRCA_PC;
            w.aluSrcB  = SRCB_FOUR;
            w.pcSource = PCSRC_ALU;
            w.irWrite  = (p == phaseIrWrite);
            w.pcWrite  = (p == phaseIrWrite);
        end
        phaseRegRead: begin
            w.regAWrite   = 1'b1;
            w.regBWrite   = 1'b1;
            w.aluOutWrite = 1'b1;
            w.aluOp       = ALU_ADD;
            w.aluSrcA     = SRCA_PC;
            w.aluSrcB     = SRCB_BRANCH;
        end
        phaseAdd, phaseSub: begin
            if (s == 0) begin
                w.aluOp       = (p == phaseAdd) ? ALU_ADD : ALU_SUB;
                w.aluSrcA     = SRCA_REGA;
                w.aluSrcB     = SRCB_REGB;
                w.aluOutWrite = 1'b1;
            end else begin
                w.regDst   = REGDST_RD;
                w.dataSrc  = DATASRC_ALUOUT;
                w.regWrite = 1'b1;
            end
        end
        phaseBreak: begin
            w.aluOp    = ALU_SUB;
            w.aluSrcA  = SRCA_PC;
            w.aluSrcB  = SRCB_FOUR;
            w.pcSource = PCSRC_ALU;
            w.pcWrite  = 1'b1;
        end
        phaseRte: begin
            w.pcSource = PCSRC_EPC;
            w.pcWrite  = 1'b1;
        end
        phaseAddm: begin
            if (s == 0 || s == 4) begin
                w.aluOp       = ALU_ADD;
                w.aluSrcA     = (s == 0) ? SRCA_REGA : SRCA_MDR;
                w.aluSrcB     = (s == 0) ? SRCB_OFFSET : SRCB_REGB;
                w.aluOutWrite = 1'b1;
            end else if (s <= 3) begin
                w.iorD     = IORD_ALUOUT;
                w.mdrWrite = (s == 3);
            end else begin
                w.regDst   = REGDST_RT;
                w.dataSrc  = DATASRC_MDRSUM;
                w.regWrite = 1'b1;
            end
        end
        phaseDivm: begin
            if (s < 3) begin
                w.iorD     = IORD_REGA;
                w.mdrWrite = (s == 2);
            end else if (s < 5) begin
                w.iorD = IORD_REGB;
            end else if (s < 5 + DIV_CYCLES) begin
                w.mdSrcA    = 1'b1;
                w.mdSrcB    = 1'b1;
                w.mdControl = 1'b1;
            end else begin
                w.hiWrite = 1'b1;
                w.loWrite = 1'b1;
            end
        end
        default: begin
            w = '0;
        end
    endcase
    return w;
endfunction

`endif

/* tests/controlUnitTb.sv */
`timescale 1ns/1ps

module controlUnitTb;
    import controlPkg::*;

    localparam int SEED        = 70;
    localparam int NUM_INSTR   = 300;
    // Longest instruction is divm at 44 cycles plus reset and slack
    localparam int CYCLE_LIMIT = NUM_INSTR * 44 + 10 + 200;

    logic         clock = 1'b0;
    logic         reset_out;
    opcode_t      opcode;
    funct_t       funct;
    controlWord_t control;
    int           cycleCount = 0;

    `include "controlModel.svh"

    controlUnit u_controlUnit (
        .clock     (clock),
        .reset_out (reset_out),
        .opcode    (opcode),
        .funct     (funct),
        .control   (control)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles with %0d of %0d instructions done",
                     cycleCount, completedCount, NUM_INSTR);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    task automatic checkControl(input controlWord_t got, input controlWord_t expected);
        if (got !== expected) begin
            $display("[FAIL] %0d ns: control in %s step %0d, differing bits %h",
                     $time, modelPhase.name(), modelStep, got ^ expected);
            $display("  got      %p", got);
            $display("  expected %p", expected);
            $display("Testbench failed");
            $fatal(1, "control word mismatch");
        end
    endtask

    // Mostly kept encodings and now and then anything at all
    task automatic driveRandom();
        int pick;
        pick   = $urandom_range(9);
        opcode = OPCODE_RTYPE;
        funct  = funct_t'($urandom_range(63));
        if (pick >= 8) begin
            opcode = opcode_t'($urandom_range(63));
        end else begin
            case ($urandom_range(5))
                0:       funct  = FUNCT_ADD;
                1:       funct  = FUNCT_SUB;
                2:       funct  = FUNCT_BREAK;
                3:       funct  = FUNCT_RTE;
                4:       funct  = FUNCT_DIVM;
                default: opcode = OPCODE_ADDM;
            endcase
        end
    endtask

    // Model steps on the rising edge and the DUT is compared at the falling edge
    task automatic runCycle();
        @(posedge clock);
        advanceModel(reset_out, opcode, funct);
        @(negedge clock);
        checkControl(control, expectedControl(modelPhase, modelStep));
    endtask

    initial begin
        void'($urandom(SEED));
        reset_out = 1'b1;
        opcode    = '0;
        funct     = '0;
        repeat (5) runCycle();
        reset_out = 1'b0;
        while (completedCount < NUM_INSTR) begin
            driveRandom();
            runCycle();
        end
        // Bits 6 to 11 mark the execute phases and bit 1 an unsupported encoding
        if (seenMask[11:6] != 6'h3f || !seenMask[1]) begin
            $display("Not every instruction kind was exercised, seen mask %b", seenMask);
            $display("Testbench failed");
            $fatal(1, "incomplete stimulus");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

/* source/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  logic                     clock,
    input  logic                     reset_out,
    input  controlPkg::opcode_t      opcode,
    input  controlPkg::funct_t       funct,
    output controlPkg::controlWord_t control
);
    import controlPkg::*;

    instrKind_t kind;
    phase_t     phase;
    step_t      step;

    instrDecoder u_instrDecoder (
        .opcode (opcode),
        .funct  (funct),
        .kind   (kind)
    );

    // Phase and step register
    controlSequencer u_controlSequencer (
        .clock     (clock),
        .reset_out (reset_out),
        .kind      (kind),
        .phase     (phase),
        .step      (step)
    );

    controlWordGen u_controlWordGen (
        .clock     (clock),
        .reset_out (reset_out),
        .phase     (phase),
        .step      (step),
        .control   (control)
    );

endmodule

/* source/controlWordGen.sv */
`timescale 1ns/1ps

module controlWordGen (
    input  logic                     clock,
    input  logic                     reset_out,
    input  controlPkg::phase_t       phase,
    input  controlPkg::step_t        step,
    output controlPkg::controlWord_t control
);
    import controlPkg::*;

    always_comb begin
        control = '0;
        case (phase)
            // Memory read at PC while the ALU forms PC+4
            phaseFetch1, phaseFetch2, phaseIrWrite: begin
                control.iorD     = IORD_PC;
                control.aluOp    = ALU_ADD;
                control.aluSrcA  = SRCA_PC;
                control.aluSrcB  = SRCB_FOUR;
                control.pcSource = PCSRC_ALU;
                if (phase == phaseIrWrite) begin
                    control.irWrite = 1'b1;
                    control.pcWrite = 1'b1;
                end
            end

            // Operand latch plus branch target into ALUOut
            phaseRegRead: begin
                control.regAWrite   = 1'b1;
                control.regBWrite   = 1'b1;
                control.aluOutWrite = 1'b1;
                control.aluOp       = ALU_ADD;
                control.aluSrcA     = SRCA_PC;
                control.aluSrcB     = SRCB_BRANCH;
            end

            phaseAdd, phaseSub: begin
                if (step == 6'd0) begin
                    control.aluOp       = (phase == phaseSub) ? ALU_SUB : ALU_ADD;
                    control.aluSrcA     = SRCA_REGA;
                    control.aluSrcB     = SRCB_REGB;
                    control.aluOutWrite = 1'b1;
                end else begin
                    control.regDst   = REGDST_RD;
                    control.dataSrc  = DATASRC_ALUOUT;
                    control.regWrite = 1'b1;
                end
            end

            // PC already advanced in fetch, so step it back
            phaseBreak: begin
                control.aluOp    = ALU_SUB;
                control.aluSrcA  = SRCA_PC;
                control.aluSrcB  = SRCB_FOUR;
                control.pcSource = PCSRC_ALU;
                control.pcWrite  = 1'b1;
            end

            phaseRte: begin
                control.pcSource = PCSRC_EPC;
                control.pcWrite  = 1'b1;
            end

            phaseAddm: begin
                case (step)
                    6'd0: begin
                        control.aluOp       = ALU_ADD;
                        control.aluSrcA     = SRCA_REGA;
                        control.aluSrcB     = SRCB_OFFSET;
                        control.aluOutWrite = 1'b1;
                    end
                    6'd1, 6'd2: begin
                        control.iorD = IORD_ALUOUT;
                    end
                    6'd3: begin
                        control.iorD     = IORD_ALUOUT;
                        control.mdrWrite = 1'b1;
                    end
                    6'd4: begin
                        control.aluOp       = ALU_ADD;
                        control.aluSrcA     = SRCA_MDR;
                        control.aluSrcB     = SRCB_REGB;
                        control.aluOutWrite = 1'b1;
                    end
                    default: begin
                        control.regDst   = REGDST_RT;
                        control.dataSrc  = DATASRC_MDRSUM;
                        control.regWrite = 1'b1;
                    end
                endcase
            end

            // Dividend from address in A, divisor from address in B
            phaseDivm: begin
                if (step <= 6'd2) begin
                    control.iorD     = IORD_REGA;
                    control.mdrWrite = (step == 6'd2);
                end else if (step < DIVM_MD_FIRST) begin
                    control.iorD = IORD_REGB;
                end else if (step < LAST_STEP_DIVM) begin
                    control.mdSrcA    = 1'b1;
                    control.mdSrcB    = 1'b1;
                    control.mdControl = 1'b1;
                end else begin
                    control.hiWrite = 1'b1;
                    control.loWrite = 1'b1;
                end
            end

            default: begin
                control = '0;
            end
        endcase
    end

    hiLoTogether: assert property (
        @(posedge clock) disable iff (reset_out)
        control.hiWrite == control.loWrite
    ) else $error("hiWrite and loWrite differ");

    noRegAndPcWrite: assert property (
        @(posedge clock) disable iff (reset_out)
        !(control.regWrite && control.pcWrite)
    ) else $error("regWrite and pcWrite raised together");

endmodule

/* source/controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer (
    input  logic                   clock,
    input  logic                   reset_out,
    input  controlPkg::instrKind_t kind,
    output controlPkg::phase_t     phase,
    output controlPkg::step_t      step
);
    import controlPkg::*;

    // Execute phase entered from decode
    function automatic phase_t execPhase(input instrKind_t k);
        case (k)
            kindAdd:   return phaseAdd;
            kindSub:   return phaseSub;
            kindBreak: return phaseBreak;
            kindRte:   return phaseRte;
            kindAddm:  return phaseAddm;
            kindDivm:  return phaseDivm;
            default:   return phaseFetch1;
        endcase
    endfunction

    // Final step of each execute phase, zero elsewhere
    function automatic step_t lastStep(input phase_t p);
        case (p)
            phaseAdd:   return LAST_STEP_ADD;
            phaseSub:   return LAST_STEP_SUB;
            phaseBreak: return LAST_STEP_BREAK;
            phaseRte:   return LAST_STEP_RTE;
            phaseAddm:  return LAST_STEP_ADDM;
            phaseDivm:  return LAST_STEP_DIVM;
            default:    return '0;
        endcase
    endfunction

    always_ff @(posedge clock) begin
        if (reset_out) begin
            phase <= phaseBoot;
            step  <= '0;
        end else begin
            case (phase)
                phaseBoot: begin
                    phase <= phaseFetch1;
                end
                phaseFetch1: begin
                    phase <= phaseFetch2;
                end
                phaseFetch2: begin
                    phase <= phaseIrWrite;
                end
                phaseIrWrite: begin
                    phase <= phaseRegRead;
                end
                phaseRegRead: begin
                    phase <= phaseDecode;
                end

                // Only edge where the instruction is looked at
                phaseDecode: begin
                    phase <= execPhase(kind);
                    step  <= '0;
                end

                default: begin
                    if (step == lastStep(phase)) begin
                        phase <= phaseFetch1;
                        step  <= '0;
                    end else begin
                        step <= step + 6'd1;
                    end
                end
            endcase
        end
    end

    // Step stays within the sequence of the current phase
    stepInRange: assert property (
        @(posedge clock) disable iff (reset_out)
        step <= lastStep(phase)
    ) else $error("step %0d beyond last step of %s", step, phase.name());

    decodeOneCycle: assert property (
        @(posedge clock) disable iff (reset_out)
        (phase == phaseDecode) |=> (phase != phaseDecode)
    ) else $error("decode phase held for more than one cycle");

endmodule

/* source/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
    input  controlPkg::opcode_t    opcode,
    input  controlPkg::funct_t     funct,
    output controlPkg::instrKind_t kind
);
    import controlPkg::*;

    always_comb begin
        kind = kindNone;
        case (opcode)
            // R-type instructions are told apart by funct
            OPCODE_RTYPE: begin
                case (funct)
                    FUNCT_ADD: begin
                        kind = kindAdd;
                    end
                    FUNCT_SUB: begin
                        kind = kindSub;
                    end
                    FUNCT_BREAK: begin
                        kind = kindBreak;
                    end
                    FUNCT_RTE: begin
                        kind = kindRte;
                    end
                    FUNCT_DIVM: begin
                        kind = kindDivm;
                    end
                    default: begin
                        kind = kindNone;
                    end
                endcase
            end

            OPCODE_ADDM: begin
                kind = kindAddm;
            end

            // Unsupported opcodes skip execute entirely
            default: begin
                kind = kindNone;
            end
        endcase
    end

endmodule

/* source/controlPkg.sv */
package controlPkg;

    // Instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // Datapath selects
    typedef logic [2:0] aluOp_t;
    typedef logic [1:0] srcSel_t;
    typedef logic [2:0] wideSel_t;

    // Execute step counter
    typedef logic [5:0] step_t;

    typedef enum logic [2:0] {
        kindAdd,
        kindSub,
        kindBreak,
        kindRte,
        kindAddm,
        kindDivm,
        kindNone
    } instrKind_t;

    typedef enum logic [3:0] {
        phaseBoot,
        phaseFetch1,
        phaseFetch2,
        phaseIrWrite,
        phaseRegRead,
        phaseDecode,
        phaseAdd,
        phaseSub,
        phaseBreak,
        phaseRte,
        phaseAddm,
        phaseDivm
    } phase_t;

    typedef struct packed {
        logic     irWrite;
        logic     pcWrite;
        logic     regWrite;
        logic     regAWrite;
        logic     regBWrite;
        logic     aluOutWrite;
        logic     mdrWrite;
        logic     hiWrite;
        logic     loWrite;
        logic     mdSrcA;
        logic     mdSrcB;
        logic     mdControl;
        aluOp_t   aluOp;
        srcSel_t  pcSource;
        srcSel_t  regDst;
        srcSel_t  aluSrcA;
        srcSel_t  aluSrcB;
        wideSel_t iorD;
        wideSel_t dataSrc;
    } controlWord_t;

    localparam opcode_t OPCODE_RTYPE = 6'b000000;
    localparam opcode_t OPCODE_ADDM  = 6'b000001;

    localparam funct_t FUNCT_ADD   = 6'b100000;
    localparam funct_t FUNCT_SUB   = 6'b100010;
    localparam funct_t FUNCT_BREAK = 6'b001101;
    localparam funct_t FUNCT_RTE   = 6'b010011;
    localparam funct_t FUNCT_DIVM  = 6'b000101;

    localparam aluOp_t ALU_ADD = 3'b001;
    localparam aluOp_t ALU_SUB = 3'b010;

    localparam srcSel_t SRCA_PC     = 2'b01;
    localparam srcSel_t SRCA_REGA   = 2'b10;
    localparam srcSel_t SRCA_MDR    = 2'b11;
    localparam srcSel_t SRCB_OFFSET = 2'b00;
    localparam srcSel_t SRCB_FOUR   = 2'b01;
    localparam srcSel_t SRCB_REGB   = 2'b10;
    localparam srcSel_t SRCB_BRANCH = 2'b11;
    localparam srcSel_t PCSRC_ALU   = 2'b01;
    localparam srcSel_t PCSRC_EPC   = 2'b11;
    localparam srcSel_t REGDST_RT   = 2'b01;
    localparam srcSel_t REGDST_RD   = 2'b11;

    localparam wideSel_t IORD_PC        = 3'b000;
    localparam wideSel_t IORD_ALUOUT    = 3'b100;
    localparam wideSel_t IORD_REGA      = 3'b101;
    localparam wideSel_t IORD_REGB      = 3'b110;
    localparam wideSel_t DATASRC_ALUOUT = 3'b100;
    localparam wideSel_t DATASRC_MDRSUM = 3'b110;

    // Divider runs after both operand reads of divm
    localparam step_t DIV_CYCLES    = 6'd33;
    localparam step_t DIVM_MD_FIRST = 6'd5;

    localparam step_t LAST_STEP_ADD   = 6'd1;
    localparam step_t LAST_STEP_SUB   = 6'd1;
    localparam step_t LAST_STEP_BREAK = 6'd0;
    localparam step_t LAST_STEP_RTE   = 6'd0;
    localparam step_t LAST_STEP_ADDM  = 6'd5;
    localparam step_t LAST_STEP_DIVM  = DIVM_MD_FIRST + DIV_CYCLES;

endpackage
